// File: verilog/bus_pkg.sv
package bus_pkg;

  typedef enum logic {
    BUS_READ,
    BUS_WRITE
  } bus_op_e;

  typedef enum logic [1:0] {
    RSP_OKAY,
    RSP_DECERR,  // Unmapped address
    RSP_WRERR    // Write to read-only space
  } rsp_status_e;

  // One single-word request, 69 bits
  typedef struct packed {
    bus_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  // One response, 34 bits
  typedef struct packed {
    logic [31:0] rdata;
    rsp_status_e status;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_DRAM,
    TGT_NONE
  } tgt_sel_e;

  // FIFO depth and the master's starting credit count
  localparam int REQ_CREDITS = 4;

  // Address map
  localparam logic [31:0] ROM_BASE   = 32'h0000_0000;
  localparam logic [31:0] ROM_SIZE   = 32'h0000_2000;
  localparam logic [31:0] SRAM_BASE  = 32'h0001_0000;
  localparam int          SRAM_WORDS = 1024;  // 4 KB
  localparam logic [31:0] DRAM_BASE  = 32'h2000_0000;
  localparam logic [31:0] DRAM_SIZE  = 32'h0020_0000;

endpackage

// File: verilog/dram_pkg.sv
package dram_pkg;

  // Pin bundle as seen by the DRAM device, 50 bits
  typedef struct packed {
    logic        csn;
    logic [3:0]  wen;   // Byte write enables, low active
    logic        rasn;
    logic        casn;
    logic [10:0] a;
    logic [31:0] d;
  } dram_pins_t;

  typedef enum logic [2:0] {
    DR_IDLE,
    DR_ROW,   // Row open, RAS low
    DR_COL,   // Column strobe
    DR_WAIT,  // Read data pending
    DR_PRE    // Precharge
  } dram_state_e;

  localparam int T_RCD = 2;
  localparam int T_RP  = 2;

  localparam dram_pins_t DRAM_IDLE_PINS = '{
    csn:  1'b1,
    wen:  4'hf,
    rasn: 1'b1,
    casn: 1'b1,
    a:    11'd0,
    d:    32'd0
  };

endpackage

// File: verilog/reset_sync.sv
`timescale 1ns/100ps

module reset_sync (
  input  logic clk,
  input  logic rst_async,
  output logic rst_sync
);

  logic meta;  // First stage, may go metastable on release

  // Assert at once, release after two clean edges
  always_ff @(posedge clk or posedge rst_async) begin
    if (rst_async) begin
      meta     <= 1'b1;
      rst_sync <= 1'b1;
    end else begin
      meta     <= 1'b0;
      rst_sync <= meta;
    end
  end

endmodule

// File: verilog/bus_fabric.sv
`timescale 1ns/100ps

module bus_fabric (
  input  logic              clk,
  input  logic              rst_sync,
  // Master side
  input  logic              req_valid,
  input  bus_pkg::mem_req_t req,
  output logic              req_credit,
  output logic              rsp_valid,
  output bus_pkg::mem_rsp_t rsp,
  input  logic              rsp_credit,
  // ROM target
  output logic              rom_start,
  output bus_pkg::mem_req_t rom_req,
  input  logic              rom_done,
  input  bus_pkg::mem_rsp_t rom_rsp,
  // SRAM target
  output logic              sram_start,
  output bus_pkg::mem_req_t sram_req,
  input  logic              sram_done,
  input  bus_pkg::mem_rsp_t sram_rsp,
  // DRAM target
  output logic              dram_start,
  output bus_pkg::mem_req_t dram_req,
  input  logic              dram_done,
  input  bus_pkg::mem_rsp_t dram_rsp
);

  import bus_pkg::*;

  typedef enum logic [1:0] {
    FB_IDLE,
    FB_BUSY,  // One target working
    FB_HOLD   // Response waits for a slot
  } fab_state_e;

  localparam int          PTR_W     = $clog2(REQ_CREDITS);
  localparam int          CNT_W     = $clog2(REQ_CREDITS + 1);
  localparam logic [31:0] SRAM_SIZE = SRAM_WORDS * 4;

  mem_req_t         fifo_mem [REQ_CREDITS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  logic [7:0]       slot_cnt;  // Granted response slots
  fab_state_e       state;
  tgt_sel_e         cur_tgt;
  tgt_sel_e         head_sel;
  mem_req_t         head;
  mem_rsp_t         hold_rsp;
  mem_rsp_t         tgt_rsp;
  logic             tgt_done;
  logic             head_err;
  logic             pop;

  // Offset compare also covers a base of zero
  function automatic tgt_sel_e decode(input logic [31:0] addr);
    tgt_sel_e sel;
    sel = TGT_NONE;
    if (addr - ROM_BASE < ROM_SIZE) sel = TGT_ROM;
    else if (addr - SRAM_BASE < SRAM_SIZE) sel = TGT_SRAM;
    else if (addr - DRAM_BASE < DRAM_SIZE) sel = TGT_DRAM;
    return sel;
  endfunction

  assign head     = fifo_mem[rd_ptr];
  assign head_sel = decode(head.addr);
  assign head_err = (head_sel == TGT_NONE) || (head_sel == TGT_ROM && head.op == BUS_WRITE);
  assign pop      = (state == FB_IDLE) && (fifo_cnt != '0);

  assign req_credit = pop;  // One credit back per pop
  assign rom_start  = pop && !head_err && head_sel == TGT_ROM;
  assign sram_start = pop && head_sel == TGT_SRAM;
  assign dram_start = pop && head_sel == TGT_DRAM;
  assign rom_req    = head;
  assign sram_req   = head;
  assign dram_req   = head;

  always_comb begin
    case (cur_tgt)
      TGT_ROM:  {tgt_done, tgt_rsp} = {rom_done, rom_rsp};
      TGT_SRAM: {tgt_done, tgt_rsp} = {sram_done, sram_rsp};
      TGT_DRAM: {tgt_done, tgt_rsp} = {dram_done, dram_rsp};
      default:  {tgt_done, tgt_rsp} = {1'b0, sram_rsp};
    endcase
  end

  assign rsp_valid = (state == FB_HOLD) && (slot_cnt != '0);
  assign rsp       = hold_rsp;

  always_ff @(posedge clk) begin
    if (req_valid) fifo_mem[wr_ptr] <= req;
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (req_valid) wr_ptr <= (wr_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      if (req_valid && !pop) fifo_cnt <= fifo_cnt + 1'b1;
      else if (pop && !req_valid) fifo_cnt <= fifo_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      state   <= FB_IDLE;
      cur_tgt <= TGT_NONE;
    end else begin
      case (state)
        FB_IDLE: if (pop) begin
          cur_tgt <= head_sel;
          state   <= head_err ? FB_HOLD : FB_BUSY;  // Errors skip the targets
        end
        FB_BUSY: if (tgt_done) state <= FB_HOLD;
        FB_HOLD: if (rsp_valid) state <= FB_IDLE;
        default: state <= FB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop && head_err) begin
      hold_rsp.rdata  <= '0;
      hold_rsp.status <= (head_sel == TGT_NONE) ? RSP_DECERR : RSP_WRERR;
    end else if (state == FB_BUSY && tgt_done) begin
      hold_rsp <= tgt_rsp;
    end
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) slot_cnt <= '0;
    else slot_cnt <= slot_cnt + {7'd0, rsp_credit} - {7'd0, rsp_valid};
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (rst_sync)
    req_valid |-> fifo_cnt != CNT_W'(REQ_CREDITS))
    else $error("Request pushed into a full FIFO");

  // Only the started target may finish, and only while the fabric waits for it
  a_one_busy: assert property (@(posedge clk) disable iff (rst_sync)
    (rom_done || sram_done || dram_done) |->
      (state == FB_BUSY) && tgt_done && $onehot({rom_done, sram_done, dram_done}))
    else $error("Done from a target that was not started");

endmodule

// File: verilog/rom_target.sv
`timescale 1ns/100ps

module rom_target (
  input  logic              clk,
  input  logic              rst_sync,
  input  logic              start,
  input  bus_pkg::mem_req_t req,
  output logic              done,
  output bus_pkg::mem_rsp_t rsp,
  // External ROM
  input  logic [31:0]       rom_out,
  output logic              rom_enable,
  output logic              rom_read,
  output logic [11:0]       rom_address
);

  import bus_pkg::*;

  // Pins active the cycle after start, data back one cycle later
  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      rom_enable <= 1'b0;
      rom_read   <= 1'b0;
      done       <= 1'b0;
    end else begin
      rom_enable <= start;
      rom_read   <= start;
      done       <= rom_enable;
    end
  end

  always_ff @(posedge clk) begin
    if (start) rom_address <= req.addr[13:2];  // Word address
  end

  // rom_out is valid during the done cycle
  assign rsp = '{rdata: rom_out, status: RSP_OKAY};

  // Fabric answers ROM writes with WRERR itself
  a_read_only: assert property (@(posedge clk) disable iff (rst_sync)
    start |-> req.op == BUS_READ)
    else $error("Write request reached the ROM target");

endmodule

// File: verilog/sram_target.sv
`timescale 1ns/100ps

module sram_target (
  input  logic              clk,
  input  logic              rst_sync,
  input  logic              start,
  input  bus_pkg::mem_req_t req,
  output logic              done,
  output bus_pkg::mem_rsp_t rsp
);

  import bus_pkg::*;

  localparam int IDX_W = $clog2(SRAM_WORDS);

  logic [31:0]      mem [SRAM_WORDS];
  logic [31:0]      rdata_q;
  logic [IDX_W-1:0] idx;

  assign idx = req.addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (start) begin
      rdata_q <= mem[idx];  // Old word on writes
      if (req.op == BUS_WRITE) begin
        for (int b = 0; b < 4; b++) begin
          if (req.wstrb[b]) mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) done <= 1'b0;
    else done <= start;  // Single-cycle access
  end

  assign rsp = '{rdata: rdata_q, status: RSP_OKAY};

endmodule

// File: verilog/dram_target.sv
`timescale 1ns/100ps

module dram_target (
  input  logic                clk,
  input  logic                rst_sync,
  input  logic                start,
  input  bus_pkg::mem_req_t   req,
  output logic                done,
  output bus_pkg::mem_rsp_t   rsp,
  // External DRAM
  input  logic                dram_valid,
  input  logic [31:0]         dram_q,
  output dram_pkg::dram_pins_t dram
);

  import bus_pkg::*;
  import dram_pkg::*;

  localparam int CNT_W = 3;

  dram_state_e      state;
  logic [CNT_W-1:0] cnt;  // Row and precharge cycles
  mem_req_t         req_q;
  logic [31:0]      rdata_q;
  dram_pins_t       pins_n;
  logic [10:0]      row;
  logic [7:0]       col;
  logic             is_write;

  assign row      = req_q.addr[20:10];
  assign col      = req_q.addr[9:2];
  assign is_write = req_q.op == BUS_WRITE;

  // Closed-page sequence with one column access per open row
  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      state <= DR_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        DR_IDLE: if (start) begin
          state <= DR_ROW;
          cnt   <= '0;
        end
        DR_ROW: begin
          if (cnt == CNT_W'(T_RCD - 1)) begin
            state <= DR_COL;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        DR_COL: state <= is_write ? DR_PRE : DR_WAIT;
        DR_WAIT: if (dram_valid) state <= DR_PRE;
        DR_PRE: begin
          if (cnt == CNT_W'(T_RP - 1)) begin
            state <= DR_IDLE;
            cnt   <= '0;
            done  <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= DR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_q   <= req;
      rdata_q <= '0;  // Writes return zero
    end else if (state == DR_WAIT && dram_valid) begin
      rdata_q <= dram_q;
    end
  end

  // Next pin values, registered below
  always_comb begin
    pins_n = DRAM_IDLE_PINS;
    case (state)
      DR_ROW: begin
        pins_n.csn  = 1'b0;
        pins_n.rasn = 1'b0;
        pins_n.a    = row;
      end
      DR_COL: begin
        pins_n.csn  = 1'b0;
        pins_n.rasn = 1'b0;
        pins_n.casn = 1'b0;
        pins_n.a    = {3'b000, col};
        if (is_write) begin
          pins_n.wen = ~req_q.wstrb;
          pins_n.d   = req_q.wdata;
        end
      end
      DR_WAIT: begin
        pins_n.csn  = 1'b0;
        pins_n.rasn = 1'b0;  // Row stays open until data returns
        pins_n.a    = {3'b000, col};
      end
      default: ;  // Idle and precharge
    endcase
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) dram <= DRAM_IDLE_PINS;
    else dram <= pins_n;
  end

  assign rsp = '{rdata: rdata_q, status: RSP_OKAY};

  // CAS only inside a row that has been open for T_RCD cycles
  a_cas_in_row: assert property (@(posedge clk) disable iff (rst_sync)
    !dram.casn |-> !dram.rasn && $past(!dram.rasn, T_RCD))
    else $error("CAS asserted before the row was open for T_RCD cycles");

endmodule

// File: verilog/mem_soc_top.sv
`timescale 1ns/100ps

module mem_soc_top (
  input  logic                 clk,
  input  logic                 rst,
  // Master
  input  logic                 req_valid,
  input  bus_pkg::mem_req_t    req,
  output logic                 req_credit,
  output logic                 rsp_valid,
  output bus_pkg::mem_rsp_t    rsp,
  input  logic                 rsp_credit,
  // ROM
  input  logic [31:0]          rom_out,
  output logic                 rom_enable,
  output logic                 rom_read,
  output logic [11:0]          rom_address,
  // DRAM
  input  logic                 dram_valid,
  input  logic [31:0]          dram_q,
  output dram_pkg::dram_pins_t dram
);

  import bus_pkg::*;

  logic     rst_sync;
  logic     rom_start, sram_start, dram_start;
  logic     rom_done, sram_done, dram_done;
  mem_req_t rom_req, sram_req, dram_req;
  mem_rsp_t rom_rsp, sram_rsp, dram_rsp;

  reset_sync u_reset_sync (
    .clk       (clk),
    .rst_async (rst),
    .rst_sync  (rst_sync)
  );

  bus_fabric u_fabric (
    .clk        (clk),
    .rst_sync   (rst_sync),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit),
    .rom_start  (rom_start),
    .rom_req    (rom_req),
    .rom_done   (rom_done),
    .rom_rsp    (rom_rsp),
    .sram_start (sram_start),
    .sram_req   (sram_req),
    .sram_done  (sram_done),
    .sram_rsp   (sram_rsp),
    .dram_start (dram_start),
    .dram_req   (dram_req),
    .dram_done  (dram_done),
    .dram_rsp   (dram_rsp)
  );

  // 0x0000_0000 .. 0x0000_1FFF
  rom_target u_rom (
    .clk         (clk),
    .rst_sync    (rst_sync),
    .start       (rom_start),
    .req         (rom_req),
    .done        (rom_done),
    .rsp         (rom_rsp),
    .rom_out     (rom_out),
    .rom_enable  (rom_enable),
    .rom_read    (rom_read),
    .rom_address (rom_address)
  );

  sram_target u_sram (  // 0x0001_0000, 4 KB
    .clk      (clk),
    .rst_sync (rst_sync),
    .start    (sram_start),
    .req      (sram_req),
    .done     (sram_done),
    .rsp      (sram_rsp)
  );

  // 0x2000_0000 .. 0x201F_FFFF
  dram_target u_dram (
    .clk        (clk),
    .rst_sync   (rst_sync),
    .start      (dram_start),
    .req        (dram_req),
    .done       (dram_done),
    .rsp        (dram_rsp),
    .dram_valid (dram_valid),
    .dram_q     (dram_q),
    .dram       (dram)
  );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // 50 MHz by default
  end

endmodule

// File: sim/tb_mem_soc.sv
`timescale 1ns/100ps

module tb_mem_soc;

  import bus_pkg::*;
  import dram_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles per wait

  // Pin values of a DRAM with no access in progress
  localparam dram_pins_t PINS_IDLE = '{csn: 1'b1, wen: 4'hf, rasn: 1'b1, casn: 1'b1,
                                       a: 11'd0, d: 32'd0};

  logic        clk;
  logic        rst;
  logic        req_valid;
  mem_req_t    req;
  logic        req_credit;
  logic        rsp_valid;
  mem_rsp_t    rsp;
  logic        rsp_credit;
  logic [31:0] rom_out;
  logic        rom_enable;
  logic        rom_read;
  logic [11:0] rom_address;
  logic        dram_valid;
  logic [31:0] dram_q;
  dram_pins_t  dram;

  int       credits;  // Request credits held by the master
  int       credit_pulses;
  int       slots;    // Granted response slots not used yet
  int       rom_pulses;
  mem_rsp_t rsp_q [$];
  string    cur_test;
  int       test_errs;
  int       err_count;
  int       tests_run;
  int       tests_failed;
  int       seed;

  // DRAM model state
  logic [31:0] dram_mem [2**19];  // Indexed by {row, col}
  logic [10:0] dram_row;
  logic        prev_rasn;
  int          rd_delay;
  logic [31:0] rd_word;

  tb_clock u_clock (.clk(clk));

  mem_soc_top DUT (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req         (req),
    .req_credit  (req_credit),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .rsp_credit  (rsp_credit),
    .rom_out     (rom_out),
    .rom_enable  (rom_enable),
    .rom_read    (rom_read),
    .rom_address (rom_address),
    .dram_valid  (dram_valid),
    .dram_q      (dram_q),
    .dram        (dram)
  );

  // ROM contents as a function of the word address
  function automatic logic [31:0] rom_word(input logic [11:0] waddr);
    return {4'ha, waddr, 4'h5, ~waddr};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  // ROM answers on the cycle after enable
  always @(posedge clk) begin : rom_model
    logic        hit;
    logic [11:0] waddr;
    hit   = rom_enable && rom_read;
    waddr = rom_address;
    if (hit) rom_pulses++;
    #2;
    if (hit) rom_out = rom_word(waddr);
  end

  always @(posedge clk) begin : dram_model
    dram_pins_t  pins;
    logic [18:0] idx;
    logic        valid_n;
    pins    = dram;
    valid_n = 1'b0;
    if (rd_delay > 0) begin
      rd_delay--;
      if (rd_delay == 0) valid_n = 1'b1;
    end
    if (!pins.csn && !pins.rasn && pins.casn && prev_rasn) dram_row = pins.a;  // RAS falls
    if (!pins.csn && !pins.casn) begin
      idx = {dram_row, pins.a[7:0]};
      if (pins.wen != 4'hf) begin
        for (int b = 0; b < 4; b++) begin
          if (!pins.wen[b]) dram_mem[idx][8*b +: 8] = pins.d[8*b +: 8];
        end
      end else begin
        rd_word  = dram_mem[idx];
        rd_delay = 2;  // Data on the third cycle after CAS
      end
    end
    prev_rasn = pins.rasn;
    #2;
    dram_valid = valid_n;
    dram_q     = valid_n ? rd_word : 32'h0;
  end

  // Credit and response monitor
  always @(posedge clk) begin
    if (!rst && req_credit === 1'b1) begin
      credits++;
      credit_pulses++;
    end
    if (!rst && rsp_valid === 1'b1) begin
      rsp_q.push_back(rsp);
      if (slots == 0) report_error("response delivered without a granted slot");
      else slots--;
    end
  end

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_run(input string what);
    $display("TIMEOUT in %s: no %s within %0d cycles", cur_test, what, TIMEOUT);
    $display("Test failures found");
    $finish;
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    err_count++;
    test_errs++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR in %s: %s", cur_test, msg);
    err_count++;
    test_errs++;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    $display("%-12s finished with %0d mismatches", cur_test, test_errs);
    tests_run++;
    if (test_errs != 0) tests_failed++;
  endtask

  task automatic send_req(input bus_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb);
    int n;
    n = 0;
    while (credits == 0) begin
      if (n == TIMEOUT) abort_run("request credit");
      step();
      n++;
    end
    req       = '{op: op, addr: addr, wdata: wdata, wstrb: strb};
    req_valid = 1'b1;
    credits--;
    step();
    req_valid = 1'b0;
  endtask

  task automatic grant_slot();
    rsp_credit = 1'b1;
    slots++;
    step();
    rsp_credit = 1'b0;
  endtask

  task automatic wait_rsp(output mem_rsp_t r);
    int n;
    n = 0;
    while (rsp_q.size() == 0) begin
      if (n == TIMEOUT) abort_run("response");
      step();
      n++;
    end
    r = rsp_q.pop_front();
  endtask

  // One request, one slot, one checked response
  task automatic access_expect(input bus_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               input rsp_status_e exp_status, input bit check_data,
                               input logic [31:0] exp_data);
    mem_rsp_t r;
    send_req(op, addr, wdata, strb);
    grant_slot();
    wait_rsp(r);
    if (r.status !== exp_status) begin
      report_mismatch($sformatf("status @%h", addr), exp_status, r.status);
    end
    if (check_data && r.rdata !== exp_data) begin
      report_mismatch($sformatf("rdata @%h", addr), exp_data, r.rdata);
    end
  endtask

  task automatic check_dram_idle();
    if (dram !== PINS_IDLE) report_mismatch("idle DRAM pins", PINS_IDLE, dram);
  endtask

  task automatic test_reset_values();
    start_test("reset");
    if (req_credit !== 1'b0) report_mismatch("req_credit", 1'b0, req_credit);
    if (rsp_valid !== 1'b0) report_mismatch("rsp_valid", 1'b0, rsp_valid);
    if (rom_enable !== 1'b0) report_mismatch("rom_enable", 1'b0, rom_enable);
    if (rom_read !== 1'b0) report_mismatch("rom_read", 1'b0, rom_read);
    check_dram_idle();
    finish_test();
  endtask

  task automatic test_sram();
    logic [31:0] word;
    start_test("sram");
    word = 32'h1122_3344;
    access_expect(BUS_WRITE, SRAM_BASE + 32'h40, word, 4'hf, RSP_OKAY, 1'b0, '0);
    access_expect(BUS_READ, SRAM_BASE + 32'h40, '0, 4'hf, RSP_OKAY, 1'b1, word);
    access_expect(BUS_WRITE, SRAM_BASE + 32'h40, 32'haabb_ccdd, 4'b0101, RSP_OKAY, 1'b0, '0);
    word = merge_bytes(word, 32'haabb_ccdd, 4'b0101);
    access_expect(BUS_READ, SRAM_BASE + 32'h40, '0, 4'hf, RSP_OKAY, 1'b1, word);
    word = 32'h5a5a_0ff0;  // Last word of the array
    access_expect(BUS_WRITE, SRAM_BASE + 32'hffc, word, 4'hf, RSP_OKAY, 1'b0, '0);
    access_expect(BUS_WRITE, SRAM_BASE + 32'hffc, 32'h7700_0000, 4'b1000, RSP_OKAY, 1'b0, '0);
    word = merge_bytes(word, 32'h7700_0000, 4'b1000);
    access_expect(BUS_READ, SRAM_BASE + 32'hffc, '0, 4'hf, RSP_OKAY, 1'b1, word);
    finish_test();
  endtask

  task automatic test_rom();
    logic [31:0] offs [4];
    int          pulses;
    start_test("rom");
    offs = '{32'h0, 32'h4, 32'h100, 32'h1ffc};
    for (int i = 0; i < 4; i++) begin
      access_expect(BUS_READ, ROM_BASE + offs[i], '0, 4'hf, RSP_OKAY, 1'b1,
                    rom_word(offs[i][13:2]));
    end
    pulses = rom_pulses;
    access_expect(BUS_WRITE, ROM_BASE + 32'h10, 32'hdead_beef, 4'hf, RSP_WRERR, 1'b1, '0);
    if (rom_pulses != pulses) report_error("ROM pins driven for a rejected write");
    finish_test();
  endtask

  task automatic test_dram();
    logic [31:0] offs [4];
    logic [31:0] words [4];
    start_test("dram");
    offs = '{32'h0000_0404, 32'h0000_0c08, 32'h001f_fffc, 32'h0000_0000};
    for (int i = 0; i < 4; i++) begin
      words[i] = 32'h1357_9bdf ^ (offs[i] << 3) ^ 32'(i);
      access_expect(BUS_WRITE, DRAM_BASE + offs[i], words[i], 4'hf, RSP_OKAY, 1'b0, '0);
      check_dram_idle();
    end
    access_expect(BUS_WRITE, DRAM_BASE + offs[1], 32'hf00d_cafe, 4'b0110, RSP_OKAY, 1'b0, '0);
    words[1] = merge_bytes(words[1], 32'hf00d_cafe, 4'b0110);
    for (int i = 0; i < 4; i++) begin
      access_expect(BUS_READ, DRAM_BASE + offs[i], '0, 4'hf, RSP_OKAY, 1'b1, words[i]);
      check_dram_idle();
    end
    finish_test();
  endtask

  task automatic test_decerr();
    logic [31:0] addrs [4];
    start_test("decerr");
    addrs = '{32'h1000_0000, 32'h0000_2000, 32'h0001_1000, 32'h2020_0000};  // Holes and ends
    for (int i = 0; i < 4; i++) begin
      access_expect(BUS_READ, addrs[i], '0, 4'hf, RSP_DECERR, 1'b1, '0);
      access_expect(BUS_WRITE, addrs[i], 32'hffff_ffff, 4'hf, RSP_DECERR, 1'b1, '0);
    end
    finish_test();
  endtask

  task automatic test_credits();
    mem_rsp_t    r;
    int          pulses0;
    logic [31:0] base;
    start_test("credits");
    base = SRAM_BASE + 32'h200;
    for (int i = 0; i < REQ_CREDITS; i++) begin
      access_expect(BUS_WRITE, base + 32'(4 * i), 32'hc0de_0000 + 32'(i), 4'hf, RSP_OKAY,
                    1'b0, '0);
    end
    if (credits != REQ_CREDITS) report_mismatch("credits before burst", REQ_CREDITS, credits);
    pulses0 = credit_pulses;
    for (int i = 0; i < REQ_CREDITS; i++) begin
      send_req(BUS_READ, base + 32'(4 * i), '0, 4'hf);
    end
    repeat (30) step();  // Watch window with no slots
    if (rsp_q.size() != 0) report_error("response delivered before any slot was granted");
    for (int i = 0; i < REQ_CREDITS; i++) begin
      grant_slot();
      wait_rsp(r);
      if (r.status !== RSP_OKAY) report_mismatch("status", RSP_OKAY, r.status);
      if (r.rdata !== 32'hc0de_0000 + 32'(i)) begin
        report_mismatch("in-order rdata", 32'hc0de_0000 + 32'(i), r.rdata);
      end
      repeat (15) step();
      if (rsp_q.size() != 0) report_error("more than one response for one slot");
      if (credit_pulses - pulses0 > REQ_CREDITS) report_error("more credits returned than spent");
    end
    if (credit_pulses - pulses0 != REQ_CREDITS) begin
      report_mismatch("credit pulses", REQ_CREDITS, credit_pulses - pulses0);
    end
    if (credits != REQ_CREDITS) report_mismatch("credits after burst", REQ_CREDITS, credits);
    finish_test();
  endtask

  task automatic test_random();
    logic [31:0] pool [8];
    logic [31:0] ref_mem [8];
    bit          written [8];
    int          idx;
    logic [31:0] data;
    logic [3:0]  strb;
    bus_op_e     op;
    start_test("random");
    // Four SRAM and four DRAM words, one per block so none collide
    for (int i = 0; i < 4; i++) begin
      pool[i]        = SRAM_BASE + 32'(i) * 32'h100 + ($random(seed) & 32'hfc);
      pool[i + 4]    = DRAM_BASE + 32'(i) * 32'h4_0000 + ($random(seed) & 32'h3_fffc);
      written[i]     = 1'b0;
      written[i + 4] = 1'b0;
    end
    for (int n = 0; n < 40; n++) begin
      idx  = $unsigned($random(seed)) % 8;
      data = $random(seed);
      strb = $random(seed);
      op   = ($random(seed) & 1) ? BUS_WRITE : BUS_READ;
      if (strb == 4'h0) strb = 4'hf;
      if (!written[idx]) begin
        op   = BUS_WRITE;  // First access fills the whole word
        strb = 4'hf;
      end
      if (op == BUS_WRITE) begin
        access_expect(BUS_WRITE, pool[idx], data, strb, RSP_OKAY, 1'b0, '0);
        ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
        written[idx] = 1'b1;
      end else begin
        access_expect(BUS_READ, pool[idx], '0, 4'hf, RSP_OKAY, 1'b1, ref_mem[idx]);
      end
    end
    finish_test();
  endtask

  initial begin
    rst           = 1'b1;
    req_valid     = 1'b0;
    req           = '0;
    rsp_credit    = 1'b0;
    rom_out       = 32'h0;
    dram_valid    = 1'b0;
    dram_q        = 32'h0;
    credits       = REQ_CREDITS;
    credit_pulses = 0;
    slots         = 0;
    rom_pulses    = 0;
    rd_delay      = 0;
    prev_rasn     = 1'b1;
    err_count     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_errs     = 0;
    cur_test      = "startup";
    seed          = 32'he355_b621;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    repeat (3) step();  // Synchronizer release
    test_reset_values();
    test_sram();
    test_rom();
    test_dram();
    test_decerr();
    test_credits();
    test_random();
    $display("%0d tests run, %0d tests failed, %0d checks failed",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: filelist.f
verilog/bus_pkg.sv
verilog/dram_pkg.sv
verilog/reset_sync.sv
verilog/bus_fabric.sv
verilog/rom_target.sv
verilog/sram_target.sv
verilog/dram_target.sv
verilog/mem_soc_top.sv
sim/tb_clock.sv
sim/tb_mem_soc.sv
